// File: source/lcd_pkg.sv
package lcd_pkg;

	// one word on the lcd bus
	typedef struct packed {
		logic       rs;    // 1 = character data, 0 = instruction
		logic [7:0] data;
	} lcd_word_t;

	typedef enum logic [1:0] {
		power_wait,
		init_seq,
		idle,
		cmd_exec
	} lcd_state_e;

	// timing in microseconds
	localparam int power_up_us  = 500;
	localparam int init_e_us    = 10;                        // enable width during init
	localparam int init_dc_us   = init_e_us + 50;            // display control start
	localparam int init_clr_us  = init_dc_us + init_e_us + 50;
	localparam int init_em_us   = init_clr_us + init_e_us + 200;
	localparam int init_end_us  = init_em_us + init_e_us + 100;
	localparam int e_start_us   = 1;
	localparam int e_end_us     = 14;
	localparam int cmd_short_us = 50;
	localparam int cmd_long_us  = 1600;                      // clear and home

	// instruction base codes
	localparam logic [7:0] clear_cmd      = 8'h01;
	localparam logic [7:0] home_cmd       = 8'h02;
	localparam logic [7:0] entry_mode_cmd = 8'h04;
	localparam logic [7:0] disp_ctrl_cmd  = 8'h08;
	localparam logic [7:0] func_set_cmd   = 8'h30;           // 8-bit bus
	localparam logic [7:0] set_ddram_cmd  = 8'h80;
	localparam logic [7:0] line2_addr     = 8'h40;           // ddram base of line 2

endpackage

// File: source/text_pkg.sv
package text_pkg;

	// display geometry
	localparam int line_cols = 16;
	localparam int col_w     = $clog2(line_cols + 1);   // column may sit at line_cols

	// host side requests
	typedef enum logic [1:0] {
		put_char,
		new_line,
		clear_disp
	} text_action_e;

	typedef enum logic [1:0] {
		ready,
		emit_addr,     // set address of the other line
		emit_char,
		emit_clear
	} writer_state_e;

endpackage

// File: source/lcd_fifo_if.sv
`timescale 1ns/1ps

interface lcd_fifo_if;

	logic               push;
	lcd_pkg::lcd_word_t wr_word;
	logic               full;
	logic               pop;
	lcd_pkg::lcd_word_t rd_word;     // head entry
	logic               empty;

	modport writer (
		output push,
		output wr_word,
		input  full
	);

	modport fifo (
		input  push,
		input  wr_word,
		output full,
		input  pop,
		output rd_word,
		output empty
	);

	modport controller (
		output pop,
		input  rd_word,
		input  empty
	);

endinterface

// File: source/lcd_text_writer.sv
`timescale 1ns/1ps

module lcd_text_writer (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   host_valid,
	input  text_pkg::text_action_e host_action,
	input  logic [7:0]             host_char,
	output logic                   host_ready,
	lcd_fifo_if.writer             fifo
);

	text_pkg::writer_state_e    state;
	text_pkg::text_action_e     act_q;       // action being worked off
	logic                       line;        // 0 = top line
	logic [text_pkg::col_w-1:0] col;
	logic [7:0]                 pend_char;
	logic                       accept;
	logic [7:0]                 other_addr;

	assign host_ready = (state == text_pkg::ready) && !fifo.full;
	assign accept     = host_valid && host_ready;
	assign fifo.push  = (state != text_pkg::ready) && !fifo.full;   // waits on back-pressure

	// column 0 of the line we are not on
	assign other_addr = line ? lcd_pkg::set_ddram_cmd
	                         : (lcd_pkg::set_ddram_cmd | lcd_pkg::line2_addr);

	always_comb begin
		fifo.wr_word.rs   = 1'b0;
		fifo.wr_word.data = 8'h00;
		case (state)
			text_pkg::emit_addr:  fifo.wr_word.data = other_addr;
			text_pkg::emit_char: begin
				fifo.wr_word.rs   = 1'b1;
				fifo.wr_word.data = pend_char;
			end
			text_pkg::emit_clear: fifo.wr_word.data = lcd_pkg::clear_cmd;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (accept)
			pend_char <= host_char;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= text_pkg::ready;
			act_q <= text_pkg::put_char;
			line  <= 1'b0;
			col   <= '0;
		end else begin
			case (state)
				text_pkg::ready: begin
					if (accept) begin
						act_q <= host_action;
						case (host_action)
							text_pkg::put_char:
								// wrap first, so the char lands at column 0
								state <= (col == text_pkg::col_w'(text_pkg::line_cols)) ?
								         text_pkg::emit_addr : text_pkg::emit_char;
							text_pkg::new_line:   state <= text_pkg::emit_addr;
							text_pkg::clear_disp: state <= text_pkg::emit_clear;
							default:              state <= text_pkg::ready;
						endcase
					end
				end
				text_pkg::emit_addr: begin
					if (!fifo.full) begin
						line  <= ~line;
						col   <= '0;
						state <= (act_q == text_pkg::put_char) ? text_pkg::emit_char
						                                       : text_pkg::ready;
					end
				end
				text_pkg::emit_char: begin
					if (!fifo.full) begin
						col   <= col + 1'b1;
						state <= text_pkg::ready;
					end
				end
				text_pkg::emit_clear: begin
					if (!fifo.full) begin
						line  <= 1'b0;    // clear homes the cursor
						col   <= '0;
						state <= text_pkg::ready;
					end
				end
				default: state <= text_pkg::ready;
			endcase
		end
	end

endmodule

// File: source/lcd_word_fifo.sv
`timescale 1ns/1ps

module lcd_word_fifo #(
	parameter int fifo_depth = 8
) (
	input  logic     clk,
	input  logic     arst_n,
	lcd_fifo_if.fifo port
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	lcd_pkg::lcd_word_t mem [fifo_depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [cnt_w-1:0]   count;      // occupancy
	logic               do_push;
	logic               do_pop;

	// wraps at depth, also for depths that are not a power of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign port.full    = (count == cnt_w'(fifo_depth));
	assign port.empty   = (count == '0);
	assign port.rd_word = mem[rd_ptr];   // head always visible

	assign do_push = port.push && !port.full;
	assign do_pop  = port.pop && !port.empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= port.wr_word;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // both or neither
			endcase
		end
	end

endmodule

// File: source/lcd_controller.sv
`timescale 1ns/1ps

module lcd_controller #(
	parameter int clk_per_us = 50
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic [6:0]     disp_cfg,    // lines, font, on, cursor, blink, inc, shift
	lcd_fifo_if.controller fifo,
	output logic           busy,
	output logic           e,
	output logic           rs,
	output logic           rw,
	output logic [7:0]     data
);

	localparam int pre_w = (clk_per_us > 1) ? $clog2(clk_per_us) : 1;
	localparam int us_w  = $clog2(lcd_pkg::cmd_long_us + 1);

	lcd_pkg::lcd_state_e state;
	logic [pre_w-1:0]    pre;          // microsecond prescaler
	logic                us_tick;
	logic [us_w-1:0]     us_cnt;       // microseconds since state entry
	logic [us_w-1:0]     exec_us;
	logic                exec_long;
	logic [8:0]          init_next;    // {e, data} for the coming microsecond

	// enable and byte of the init sequence at microsecond t
	function automatic logic [8:0] init_step(input logic [us_w-1:0] t, input logic [6:0] cfg);
		logic       e_on;
		logic [7:0] cmd;
		e_on = 1'b1;
		if (t < us_w'(lcd_pkg::init_e_us))
			cmd = lcd_pkg::func_set_cmd | {4'b0000, cfg[6:5], 2'b00};
		else if (t >= us_w'(lcd_pkg::init_dc_us) &&
		         t < us_w'(lcd_pkg::init_dc_us + lcd_pkg::init_e_us))
			cmd = lcd_pkg::disp_ctrl_cmd | {5'b00000, cfg[4:2]};
		else if (t >= us_w'(lcd_pkg::init_clr_us) &&
		         t < us_w'(lcd_pkg::init_clr_us + lcd_pkg::init_e_us))
			cmd = lcd_pkg::clear_cmd;
		else if (t >= us_w'(lcd_pkg::init_em_us) &&
		         t < us_w'(lcd_pkg::init_em_us + lcd_pkg::init_e_us))
			cmd = lcd_pkg::entry_mode_cmd | {6'b000000, cfg[1:0]};
		else begin
			e_on = 1'b0;     // gap between steps
			cmd  = 8'h00;
		end
		return {e_on, cmd};
	endfunction

	assign us_tick   = (pre == pre_w'(clk_per_us - 1));
	assign init_next = init_step(us_cnt + 1'b1, disp_cfg);

	// clear and home need the long wait
	assign exec_long = !rs && (data == lcd_pkg::clear_cmd || data == lcd_pkg::home_cmd);
	assign exec_us   = exec_long ? us_w'(lcd_pkg::cmd_long_us) : us_w'(lcd_pkg::cmd_short_us);

	assign fifo.pop = (state == lcd_pkg::idle) && !fifo.empty;
	assign rw       = 1'b0;            // write only

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= lcd_pkg::power_wait;
			pre    <= '0;
			us_cnt <= '0;
			busy   <= 1'b1;
			e      <= 1'b0;
			rs     <= 1'b0;
			data   <= 8'h00;
		end else begin
			pre <= us_tick ? '0 : pre + 1'b1;
			if (us_tick)
				us_cnt <= us_cnt + 1'b1;

			case (state)
				lcd_pkg::power_wait: begin
					if (us_tick && us_cnt == us_w'(lcd_pkg::power_up_us - 1)) begin
						state     <= lcd_pkg::init_seq;
						us_cnt    <= '0;
						{e, data} <= init_step('0, disp_cfg);   // function set right away
					end
				end
				lcd_pkg::init_seq: begin
					if (us_tick) begin
						if (us_cnt == us_w'(lcd_pkg::init_end_us - 1)) begin
							state  <= lcd_pkg::idle;
							us_cnt <= '0;
							busy   <= 1'b0;
						end else begin
							{e, data} <= init_next;
						end
					end
				end
				lcd_pkg::idle: begin
					if (!fifo.empty) begin
						state  <= lcd_pkg::cmd_exec;
						pre    <= '0;                  // align timing to the pop
						us_cnt <= '0;
						busy   <= 1'b1;
						rs     <= fifo.rd_word.rs;
						data   <= fifo.rd_word.data;
					end
				end
				lcd_pkg::cmd_exec: begin
					if (us_tick) begin
						if (us_cnt == us_w'(lcd_pkg::e_start_us - 1))
							e <= 1'b1;
						if (us_cnt == us_w'(lcd_pkg::e_end_us - 1))
							e <= 1'b0;
						if (us_cnt == exec_us - 1'b1) begin
							state  <= lcd_pkg::idle;
							us_cnt <= '0;
							busy   <= 1'b0;
							rs     <= 1'b0;
							data   <= 8'h00;
						end
					end
				end
				default: state <= lcd_pkg::power_wait;
			endcase
		end
	end

endmodule

// File: source/lcd_subsystem.sv
`timescale 1ns/1ps

module lcd_subsystem #(
	parameter int clk_per_us = 50,
	parameter int fifo_depth = 8
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [6:0]             disp_cfg,
	input  logic                   host_valid,
	input  text_pkg::text_action_e host_action,
	input  logic [7:0]             host_char,
	output logic                   host_ready,
	output logic                   lcd_busy,
	output logic                   lcd_e,
	output logic                   lcd_rs,
	output logic                   lcd_rw,
	output logic [7:0]             lcd_data
);

	lcd_fifo_if fifo_bus ();

	lcd_text_writer u_writer (
		.clk         (clk),
		.arst_n      (arst_n),
		.host_valid  (host_valid),
		.host_action (host_action),
		.host_char   (host_char),
		.host_ready  (host_ready),
		.fifo        (fifo_bus.writer)
	);

	lcd_word_fifo #(
		.fifo_depth (fifo_depth)
	) u_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.port   (fifo_bus.fifo)
	);

	lcd_controller #(
		.clk_per_us (clk_per_us)
	) u_controller (
		.clk      (clk),
		.arst_n   (arst_n),
		.disp_cfg (disp_cfg),
		.fifo     (fifo_bus.controller),
		.busy     (lcd_busy),
		.e        (lcd_e),
		.rs       (lcd_rs),
		.rw       (lcd_rw),
		.data     (lcd_data)
	);

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#2 arst_n = 1'b1;          // release away from the edge
	end

endmodule

// File: dv/lcd_properties.sv
`timescale 1ns/1ps

module lcd_properties (
	input logic       clk,
	input logic       arst_n,
	input logic       e,
	input logic       rw,
	input logic [7:0] data,
	input logic       push,
	input logic       full,
	input logic       pop,
	input logic       empty
);

	int fail_cnt = 0;          // read by the testbench at the end

	rw_low: assert property (@(posedge clk) disable iff (!arst_n) !rw)
		else begin
			fail_cnt++;
			$error("lcd_rw went high on a write-only bus");
		end

	// the byte may change only on the cycle that e falls
	data_stable: assert property (@(posedge clk) disable iff (!arst_n)
		e |=> (!e || $stable(data)))
		else begin
			fail_cnt++;
			$error("lcd_data changed while lcd_e was high");
		end

	push_ok: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
		else begin
			fail_cnt++;
			$error("push while the word fifo was full");
		end

	pop_ok: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
		else begin
			fail_cnt++;
			$error("pop while the word fifo was empty");
		end

endmodule

bind lcd_controller lcd_properties i_pin_props (
	.clk (clk), .arst_n (arst_n), .e (e), .rw (rw), .data (data),
	.push (1'b0), .full (1'b0), .pop (fifo.pop), .empty (fifo.empty)
);

bind lcd_word_fifo lcd_properties i_fifo_props (
	.clk (clk), .arst_n (arst_n), .e (1'b0), .rw (1'b0), .data (8'h00),
	.push (port.push), .full (port.full), .pop (port.pop), .empty (port.empty)
);

// File: dv/lcd_subsystem_tb.sv
`timescale 1ns/1ps

module lcd_subsystem_tb;

	localparam int clk_per_us    = 2;
	localparam int fifo_depth    = 4;
	localparam int drive_skew    = 2;        // ns after the rising edge
	localparam int reset_timeout = 100;      // all timeouts in cycles
	localparam int init_timeout  = 3000;
	localparam int ready_timeout = 15000;
	localparam int drain_timeout = 40000;

	typedef struct {
		text_pkg::text_action_e action;
		logic [7:0]             ch;
		int                     gap;         // idle cycles after the strobe
	} stim_t;

	logic                   clk;
	logic                   arst_n;
	logic [6:0]             disp_cfg;
	logic                   host_valid;
	text_pkg::text_action_e host_action;
	logic [7:0]             host_char;
	logic                   host_ready;
	logic                   lcd_busy;
	logic                   lcd_e;
	logic                   lcd_rs;
	logic                   lcd_rw;
	logic [7:0]             lcd_data;

	stim_t              stim_table [$];
	lcd_pkg::lcd_word_t exp_q [$];           // words still to appear on the bus
	int   value_errors = 0;
	int   other_errors = 0;
	int   timeouts = 0;
	int   assert_errors = 0;
	bit   timed_out = 0;
	bit   saw_backpressure = 0;
	logic model_line = 1'b0;                 // cursor model
	int   model_col = 0;
	int   cycle_cnt = 0;
	int   pulse_cnt = 0;
	int   rise_cycle = 0;
	logic e_prev = 1'b0;
	logic prev_long = 1'b0;

	tb_clock_gen #(.period_ns(20), .reset_cycles(8)) i_clk_gen (.clk(clk), .arst_n(arst_n));

	lcd_subsystem #(
		.clk_per_us (clk_per_us),
		.fifo_depth (fifo_depth)
	) i_dut (
		.clk (clk), .arst_n (arst_n), .disp_cfg (disp_cfg),
		.host_valid (host_valid), .host_action (host_action), .host_char (host_char),
		.host_ready (host_ready), .lcd_busy (lcd_busy), .lcd_e (lcd_e),
		.lcd_rs (lcd_rs), .lcd_rw (lcd_rw), .lcd_data (lcd_data)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic expect_word(input logic rs, input logic [7:0] data);
		lcd_pkg::lcd_word_t w;
		w.rs   = rs;
		w.data = data;
		exp_q.push_back(w);
	endtask

	// ddram address of column 0 on the other line
	task automatic model_wrap();
		expect_word(1'b0, model_line ? 8'h80 : 8'hc0);
		model_line = ~model_line;
		model_col  = 0;
	endtask

	task automatic model_action(input text_pkg::text_action_e action, input logic [7:0] ch);
		case (action)
			text_pkg::put_char: begin
				if (model_col == text_pkg::line_cols)
					model_wrap();            // wrap before writing
				expect_word(1'b1, ch);
				model_col++;
			end
			text_pkg::new_line: model_wrap();
			text_pkg::clear_disp: begin
				expect_word(1'b0, 8'h01);
				model_line = 1'b0;
				model_col  = 0;
			end
			default: ;
		endcase
	endtask

	function automatic logic [7:0] random_char();
		return 8'(8'h20 + $urandom % 95);    // printable ascii
	endfunction

	task automatic add_stim(input text_pkg::text_action_e action, input logic [7:0] ch,
	                        input int gap);
		stim_t s;
		s.action = action;
		s.ch     = ch;
		s.gap    = gap;
		stim_table.push_back(s);
	endtask

	task automatic fill_table();
		add_stim(text_pkg::put_char, "H", 3);
		add_stim(text_pkg::put_char, "i", 3);
		add_stim(text_pkg::new_line, 8'h00, 1);
		for (int i = 0; i < 20; i++)
			add_stim(text_pkg::put_char, random_char(), $urandom % 4);   // wraps once
		add_stim(text_pkg::clear_disp, 8'h00, 2);
		for (int i = 0; i < 17; i++)
			add_stim(text_pkg::put_char, random_char(), 0);             // burst
		add_stim(text_pkg::put_char, "x", 0);
		add_stim(text_pkg::clear_disp, 8'h00, 0);    // cleared from the second line
		add_stim(text_pkg::new_line, 8'h00, 0);
		add_stim(text_pkg::put_char, "y", 5);
	endtask

	task automatic send_action(input stim_t s);
		int waited;
		waited = 0;
		while (!host_ready && waited < ready_timeout) begin
			@(posedge clk);
			#drive_skew;
			waited++;
		end
		if (waited > 2)
			saw_backpressure = 1'b1;         // longer than a wrap takes
		if (!host_ready) begin
			$display("timeout: host_ready stayed low for %0d cycles", waited);
			timeouts++;
			timed_out = 1'b1;
		end else begin
			host_valid  = 1'b1;
			host_action = s.action;
			host_char   = s.ch;
			model_action(s.action, s.ch);
			@(posedge clk);
			#drive_skew;
			host_valid = 1'b0;
			repeat (s.gap) begin
				@(posedge clk);
				#drive_skew;
			end
		end
	endtask

	// bus monitor, sampled on the falling edge
	always @(negedge clk) begin
		lcd_pkg::lcd_word_t w;
		int min_gap;
		logic cur_long;
		cycle_cnt++;
		if (lcd_e && !e_prev) begin
			cur_long = 1'b0;
			if (exp_q.size() == 0) begin
				$display("lcd_e pulse at %0t ns carried a word that was never sent", $time);
				other_errors++;
			end else begin
				w = exp_q.pop_front();
				check_value("lcd_rs", w.rs, lcd_rs);
				check_value("lcd_data", w.data, lcd_data);
				cur_long = !w.rs && (w.data == 8'h01 || w.data == 8'h02);
			end
			min_gap = (prev_long ? 1600 : 50) * clk_per_us;
			if (pulse_cnt >= 5 && cycle_cnt - rise_cycle < min_gap) begin
				$display("enable pulses at %0t ns only %0d cycles apart", $time,
				         cycle_cnt - rise_cycle);
				other_errors++;
			end
			prev_long  = cur_long;
			rise_cycle = cycle_cnt;
			pulse_cnt++;
		end
		// init pulses are 10 us wide, command pulses 13 us
		if (!lcd_e && e_prev &&
		    cycle_cnt - rise_cycle < (pulse_cnt <= 4 ? 10 : 13) * clk_per_us) begin
			$display("enable pulse ending at %0t ns was too short", $time);
			other_errors++;
		end
		e_prev = lcd_e;
	end

	initial begin
		int waited;
		disp_cfg    = 7'b1011010;            // 2 lines, on, cursor, increment
		host_valid  = 1'b0;
		host_action = text_pkg::put_char;
		host_char   = 8'h00;
		void'($urandom(97544));
		fill_table();
		// function set, display control, clear, entry mode
		expect_word(1'b0, {3'b001, 1'b1, disp_cfg[6], disp_cfg[5], 2'b00});
		expect_word(1'b0, {5'b00001, disp_cfg[4], disp_cfg[3], disp_cfg[2]});
		expect_word(1'b0, 8'h01);
		expect_word(1'b0, {6'b000001, disp_cfg[1], disp_cfg[0]});

		waited = 0;
		while (arst_n !== 1'b1 && waited < reset_timeout) begin
			@(posedge clk);
			waited++;
		end
		if (arst_n !== 1'b1) begin
			$display("timeout: reset was never released");
			timeouts++;
			timed_out = 1'b1;
		end
		@(posedge clk);
		#drive_skew;
		check_value("lcd_e", 1'b0, lcd_e);
		check_value("lcd_rs", 1'b0, lcd_rs);
		check_value("lcd_rw", 1'b0, lcd_rw);
		check_value("lcd_data", 8'h00, lcd_data);
		check_value("lcd_busy", 1'b1, lcd_busy);

		waited = 0;
		while (lcd_busy && waited < init_timeout) begin
			@(posedge clk);
			#drive_skew;
			waited++;
		end
		if (lcd_busy) begin
			$display("timeout: lcd_busy never fell after initialization");
			timeouts++;
			timed_out = 1'b1;
		end else begin
			check_value("init pulse count", 4, pulse_cnt);
		end

		foreach (stim_table[i]) begin
			if (timed_out)
				break;
			send_action(stim_table[i]);
		end

		waited = 0;
		while (!timed_out && (exp_q.size() != 0 || lcd_busy) && waited < drain_timeout) begin
			@(posedge clk);
			#drive_skew;
			waited++;
		end
		if (!timed_out && (exp_q.size() != 0 || lcd_busy)) begin
			$display("timeout: %0d words never reached the lcd bus", exp_q.size());
			timeouts++;
		end
		if (!timed_out) begin
			@(posedge clk);
			#drive_skew;
			check_value("lcd_busy", 1'b0, lcd_busy);     // nothing left in the fifo
		end
		if (!timed_out && !saw_backpressure) begin
			$display("host_ready never dropped for a full fifo during the burst");
			other_errors++;
		end

		assert_errors = i_dut.u_controller.i_pin_props.fail_cnt +
		                i_dut.u_fifo.i_fifo_props.fail_cnt;
		$display("errors: %0d value, %0d other, %0d timeout, %0d assertion", value_errors,
		         other_errors, timeouts, assert_errors);
		if (value_errors + other_errors + timeouts + assert_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: compile.f
source/lcd_pkg.sv
source/text_pkg.sv
source/lcd_fifo_if.sv
source/lcd_text_writer.sv
source/lcd_word_fifo.sv
source/lcd_controller.sv
source/lcd_subsystem.sv
dv/tb_clock_gen.sv
dv/lcd_properties.sv
dv/lcd_subsystem_tb.sv
